//--- hdl/mipsPkg.sv
/*
  MIPS32 subset definitions
  opcode and funct encodings, ALU operations, write-back sources
*/
`default_nettype none

package mipsPkg;

  // ====================
  // vector types
  // ====================
  // data, address or instruction word
  typedef logic [31:0] word_t;
  // register number
  typedef logic [4:0] regIdx_t;
  // instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  // ====================
  // control encodings
  // ====================
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOp_t;

  // what goes back into the register file
  typedef enum logic [1:0] {
    wbAlu,
    wbMem,
    wbLink
  } wbSel_t;

  // primary opcodes
  localparam opcode_t opR   = 6'b000000;
  localparam opcode_t opJ   = 6'b000010;
  localparam opcode_t opJal = 6'b000011;
  localparam opcode_t opBeq = 6'b000100;
  localparam opcode_t opLw  = 6'b100011;
  localparam opcode_t opSw  = 6'b101011;

  // R-type funct codes
  localparam funct_t fnJr  = 6'b001000;
  localparam funct_t fnAdd = 6'b100000;
  localparam funct_t fnSub = 6'b100010;
  localparam funct_t fnAnd = 6'b100100;
  localparam funct_t fnOr  = 6'b100101;
  localparam funct_t fnSlt = 6'b101010;

endpackage

`default_nettype wire

//--- hdl/pcUnit.sv
/*
  program counter
  holds pc and picks the next fetch address
*/
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          jump,
  input  wire logic          jumpReg,
  input  wire logic          branch,
  input  wire logic          zero,
  input  wire logic [25:0]   jumpField,
  input  mipsPkg::word_t     branchOffset,
  input  mipsPkg::word_t     rsValue,
  output mipsPkg::word_t     pc,
  output mipsPkg::word_t     linkAddr
);

  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t branchTarget;
  mipsPkg::word_t jumpTarget;
  mipsPkg::word_t pcNext;

  // ====================
  // candidate targets
  // ====================
  assign pcPlus4 = pc + 32'd4;
  // word offset, relative to the following instruction
  assign branchTarget = pcPlus4 + {branchOffset[29:0], 2'b00};
  // pseudo-direct, top nibble from pc+4
  assign jumpTarget = {pcPlus4[31:28], jumpField, 2'b00};
  // return address for jal
  assign linkAddr = pc + 32'd8;

  // jr beats j/jal beats taken beq
  always_comb begin
    if (jumpReg) begin
      pcNext = rsValue;
    end else if (jump) begin
      pcNext = jumpTarget;
    end else if (branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

//--- hdl/controlDecoder.sv
/*
  instruction decoder
  opcode and funct to datapath controls and ALU operation in one level
*/
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
  input  mipsPkg::word_t     ir,
  output logic               regDst,
  output logic               aluSrc,
  output logic               regWrite,
  output logic               memRead,
  output logic               memWrite,
  output logic               branch,
  output logic               jump,
  output logic               jumpReg,
  output mipsPkg::wbSel_t    wbSel,
  output mipsPkg::aluOp_t    aluOp,
  output logic               destSel31
);

  mipsPkg::opcode_t opcode;
  mipsPkg::funct_t  funct;

  assign opcode = ir[31:26];
  assign funct  = ir[5:0];

  always_comb begin
    // defaults give a no-op with sequential pc
    regDst    = 1'b0;
    aluSrc    = 1'b0;
    regWrite  = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    jumpReg   = 1'b0;
    destSel31 = 1'b0;
    wbSel     = mipsPkg::wbAlu;
    aluOp     = mipsPkg::aluAdd;

    case (opcode)
      mipsPkg::opR: begin
        // rd destination, both operands from registers
        regDst = 1'b1;
        case (funct)
          mipsPkg::fnAdd: begin
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluAdd;
          end
          mipsPkg::fnSub: begin
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluSub;
          end
          mipsPkg::fnAnd: begin
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluAnd;
          end
          mipsPkg::fnOr: begin
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluOr;
          end
          mipsPkg::fnSlt: begin
            regWrite = 1'b1;
            aluOp    = mipsPkg::aluSlt;
          end
          // jr only redirects, nothing retires to the register file
          mipsPkg::fnJr: jumpReg = 1'b1;
          default: ;
        endcase
      end
      mipsPkg::opLw: begin
        // base plus offset, loaded word into rt
        aluSrc   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
        wbSel    = mipsPkg::wbMem;
      end
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        // equality through subtract and zero flag
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ: jump = 1'b1;
      mipsPkg::opJal: begin
        jump      = 1'b1;
        regWrite  = 1'b1;
        destSel31 = 1'b1;
        wbSel     = mipsPkg::wbLink;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
/*
  register file, 32 x 32 bits
  two combinational reads, one write at the clock edge, r0 reads zero
*/
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          writeEn,
  input  mipsPkg::regIdx_t   readAddr1,
  input  mipsPkg::regIdx_t   readAddr2,
  input  mipsPkg::regIdx_t   writeAddr,
  input  mipsPkg::word_t     writeData,
  output mipsPkg::word_t     readData1,
  output mipsPkg::word_t     readData2
);

  mipsPkg::word_t regs [32];

  // ====================
  // write port
  // ====================
  // whole array cleared while in reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      // r0 never takes a write
      regs[writeAddr] <= writeData;
    end
  end

  // ====================
  // read ports
  // ====================
  // r0 hardwired to zero
  always_comb begin
    if (readAddr1 == 5'd0) begin
      readData1 = '0;
    end else begin
      readData1 = regs[readAddr1];
    end
  end

  always_comb begin
    if (readAddr2 == 5'd0) begin
      readData2 = '0;
    end else begin
      readData2 = regs[readAddr2];
    end
  end

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
/*
  ALU
  add, sub, and, or, signed slt, plus zero flag
*/
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  mipsPkg::word_t     a,
  input  mipsPkg::word_t     b,
  input  mipsPkg::aluOp_t    op,
  output mipsPkg::word_t     result,
  output logic               zero
);

  logic lessThan;

  // two's complement compare
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      mipsPkg::aluAdd: begin
        result = a + b;
      end
      mipsPkg::aluSub: begin
        result = a - b;
      end
      mipsPkg::aluAnd: begin
        result = a & b;
      end
      mipsPkg::aluOr: begin
        result = a | b;
      end
      mipsPkg::aluSlt: begin
        // 1 or 0 in the low bit
        result = {31'd0, lessThan};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // raw flag, the pc logic qualifies it with branch
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hdl/memAccess.sv
/*
  data memory side
  active-low SRAM strobes, word address, write-back source select
*/
`timescale 1ns/1ps
`default_nettype none

module memAccess #(
  parameter int DataAddrWidth = 7
) (
  input  wire logic                       rst,
  input  wire logic                       memRead,
  input  wire logic                       memWrite,
  input  mipsPkg::wbSel_t                 wbSel,
  input  mipsPkg::word_t                  aluResult,
  input  mipsPkg::word_t                  storeData,
  input  mipsPkg::word_t                  linkAddr,
  input  mipsPkg::word_t                  memReadData,
  output logic                            memCen,
  output logic                            memWen,
  output logic [DataAddrWidth-1:0]        memAddr,
  output mipsPkg::word_t                  memWriteData,
  output mipsPkg::word_t                  wbData
);

  // ====================
  // SRAM pins
  // ====================
  // both strobes idle high in reset
  assign memCen = !rst || !(memRead || memWrite);
  assign memWen = !rst || !memWrite;

  // byte address to word address
  assign memAddr      = aluResult[DataAddrWidth+1:2];
  assign memWriteData = storeData;

  // write-back source
  always_comb begin
    case (wbSel)
      mipsPkg::wbMem: begin
        wbData = memReadData;
      end
      mipsPkg::wbLink: begin
        wbData = linkAddr;
      end
      default: begin
        wbData = aluResult;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/singleCycleMips.sv
/*
  single-cycle MIPS32 subset core
  one instruction retired per clock, external instruction memory and data SRAM
*/
`timescale 1ns/1ps
`default_nettype none

module singleCycleMips #(
  parameter int DataAddrWidth = 7
) (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // instruction memory
  output mipsPkg::word_t              irAddr,
  input  mipsPkg::word_t              ir,
  // data SRAM
  output logic                        memCen,
  output logic                        memWen,
  output logic [DataAddrWidth-1:0]    memAddr,
  output mipsPkg::word_t              memWriteData,
  input  mipsPkg::word_t              memReadData,
  // retire trace
  output logic                        rfWriteEn,
  output mipsPkg::regIdx_t            rfWriteAddr,
  output mipsPkg::word_t              rfWriteData
);

  logic             regDst, aluSrc, regWrite, memRead, memWrite;
  logic             branch, jump, jumpReg, destSel31, zero;
  mipsPkg::wbSel_t  wbSel;
  mipsPkg::aluOp_t  aluOp;
  mipsPkg::word_t   rsValue, rtValue, signImm, aluB, aluResult, linkAddr;

  // ====================
  // fetch and decode
  // ====================
  pcUnit uPc (
    .clk(clk), .rst(rst), .jump(jump), .jumpReg(jumpReg), .branch(branch),
    .zero(zero), .jumpField(ir[25:0]), .branchOffset(signImm),
    .rsValue(rsValue), .pc(irAddr), .linkAddr(linkAddr)
  );

  controlDecoder uDec (
    .ir(ir), .regDst(regDst), .aluSrc(aluSrc), .regWrite(regWrite),
    .memRead(memRead), .memWrite(memWrite), .branch(branch), .jump(jump),
    .jumpReg(jumpReg), .wbSel(wbSel), .aluOp(aluOp), .destSel31(destSel31)
  );

  // immediate and destination select
  assign signImm     = {{16{ir[15]}}, ir[15:0]};
  assign rfWriteAddr = destSel31 ? 5'd31 : (regDst ? ir[15:11] : ir[20:16]);
  // no retire while reset holds the core
  assign rfWriteEn   = regWrite && rst;

  // ====================
  // execute
  // ====================
  regFile uRf (
    .clk(clk), .rst(rst), .writeEn(rfWriteEn), .readAddr1(ir[25:21]),
    .readAddr2(ir[20:16]), .writeAddr(rfWriteAddr), .writeData(rfWriteData),
    .readData1(rsValue), .readData2(rtValue)
  );

  // second operand, rt or offset
  assign aluB = aluSrc ? signImm : rtValue;

  aluUnit uAlu (
    .a(rsValue), .b(aluB), .op(aluOp), .result(aluResult), .zero(zero)
  );

  // memory and write-back
  memAccess #(.DataAddrWidth(DataAddrWidth)) uMem (
    .rst(rst), .memRead(memRead), .memWrite(memWrite), .wbSel(wbSel),
    .aluResult(aluResult), .storeData(rtValue), .linkAddr(linkAddr),
    .memReadData(memReadData), .memCen(memCen), .memWen(memWen),
    .memAddr(memAddr), .memWriteData(memWriteData), .wbData(rfWriteData)
  );

endmodule

`default_nettype wire

//--- tests/singleCycleMips_chk.sv
/*
  bound checker for the core
  SRAM strobe pairing, reset state and fetch alignment
*/
`timescale 1ns/1ps
`default_nettype none

module singleCycleMipsChk (
  input wire logic           clk,
  input wire logic           rst,
  input wire mipsPkg::word_t irAddr,
  input wire logic           memCen,
  input wire logic           memWen,
  input wire logic           rfWriteEn
);

  // running count of assertion failures
  int failures = 0;

  // ====================
  // SRAM strobes
  // ====================
  // a write always comes with chip enable
  strobePair: assert property (@(posedge clk) !memWen |-> !memCen)
    else begin
      failures++;
      $error("memWen low while memCen is high");
    end

  // idle SRAM and no retire while held in reset
  resetState: assert property (@(posedge clk) !rst |-> (memCen && memWen && !rfWriteEn))
    else begin
      failures++;
      $error("SRAM strobes or register write active during reset");
    end

  // ====================
  // fetch
  // ====================
  fetchAligned: assert property (@(posedge clk) irAddr[1:0] == 2'b00)
    else begin
      failures++;
      $error("irAddr not word aligned");
    end

endmodule

bind singleCycleMips singleCycleMipsChk chk (
  .clk(clk),
  .rst(rst),
  .irAddr(irAddr),
  .memCen(memCen),
  .memWen(memWen),
  .rfWriteEn(rfWriteEn)
);

`default_nettype wire

//--- tests/singleCycleMipsTb.sv
/*
  testbench for the single-cycle MIPS core
  instruction ROM, data SRAM model, reference model compared every cycle
*/
`timescale 1ns/1ps
`default_nettype none

module singleCycleMipsTb;

  localparam int DataAddrWidth = 7;
  localparam int MemWords      = 2**DataAddrWidth;
  localparam int ResetCycles   = 5;
  localparam int NumCycles     = 24;
  localparam int ClkPeriod     = 40;
  // twice the expected run, reset included
  localparam int WatchdogNs    = (NumCycles + ResetCycles) * ClkPeriod * 2;

  logic                     clk;
  logic                     rst;
  mipsPkg::word_t           irAddr;
  mipsPkg::word_t           ir;
  logic                     memCen;
  logic                     memWen;
  logic [DataAddrWidth-1:0] memAddr;
  mipsPkg::word_t           memWriteData;
  mipsPkg::word_t           memReadData;
  logic                     rfWriteEn;
  mipsPkg::regIdx_t         rfWriteAddr;
  mipsPkg::word_t           rfWriteData;

  mipsPkg::word_t rom [64];
  mipsPkg::word_t sram [MemWords];

  // reference model state
  mipsPkg::word_t refPc;
  mipsPkg::word_t refRegs [32];
  mipsPkg::word_t refMem [MemWords];

  int errors;
  int checks;

  singleCycleMips #(.DataAddrWidth(DataAddrWidth)) dut (
    .clk(clk), .rst(rst), .irAddr(irAddr), .ir(ir),
    .memCen(memCen), .memWen(memWen), .memAddr(memAddr),
    .memWriteData(memWriteData), .memReadData(memReadData),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // ====================
  // memories
  // ====================
  assign ir          = rom[irAddr[7:2]];
  assign memReadData = sram[memAddr];

  // SRAM write at the same edge that retires the sw
  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      sram[memAddr] <= memWriteData;
    end
  end

  function automatic mipsPkg::word_t xorshift(input mipsPkg::word_t x);
    mipsPkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // instruction encoders
  function automatic mipsPkg::word_t rType(input int rs, input int rt, input int rd,
                                           input mipsPkg::funct_t fn);
    return {mipsPkg::opR, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic mipsPkg::word_t iType(input mipsPkg::opcode_t op, input int rs,
                                           input int rt, input int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic mipsPkg::word_t jType(input mipsPkg::opcode_t op, input int target);
    return {op, target[25:0]};
  endfunction

  task automatic loadProgram();
    for (int i = 0; i < 64; i++) begin
      rom[i] = '0;
    end
    // two operands from the preloaded SRAM
    rom[0]  = iType(mipsPkg::opLw, 0, 1, 0);
    rom[1]  = iType(mipsPkg::opLw, 0, 2, 4);
    rom[2]  = rType(1, 2, 3, mipsPkg::fnAdd);
    rom[3]  = rType(1, 2, 4, mipsPkg::fnSub);
    rom[4]  = rType(1, 2, 5, mipsPkg::fnAnd);
    rom[5]  = rType(1, 2, 6, mipsPkg::fnOr);
    rom[6]  = rType(1, 2, 7, mipsPkg::fnSlt);
    // zero against negative r1 separates signed from unsigned
    rom[7]  = rType(0, 1, 8, mipsPkg::fnSlt);
    // store then load back
    rom[8]  = iType(mipsPkg::opSw, 0, 3, 8);
    rom[9]  = iType(mipsPkg::opLw, 0, 9, 8);
    // r0 write, then read through r0
    rom[10] = rType(1, 2, 0, mipsPkg::fnAdd);
    rom[11] = rType(0, 1, 10, mipsPkg::fnAdd);
    // not taken, then taken over 14 and 15
    rom[12] = iType(mipsPkg::opBeq, 1, 2, 5);
    rom[13] = iType(mipsPkg::opBeq, 10, 1, 2);
    rom[14] = rType(1, 1, 11, mipsPkg::fnAdd);
    rom[15] = rType(1, 1, 12, mipsPkg::fnAdd);
    // call, link is pc+8 so 17 is skipped on return
    rom[16] = jType(mipsPkg::opJal, 20);
    rom[17] = rType(1, 1, 14, mipsPkg::fnAdd);
    rom[18] = jType(mipsPkg::opJ, 24);
    rom[19] = rType(1, 1, 13, mipsPkg::fnAdd);
    // subroutine
    rom[20] = rType(2, 2, 15, mipsPkg::fnAdd);
    rom[21] = iType(mipsPkg::opSw, 0, 15, 12);
    rom[22] = rType(31, 0, 0, mipsPkg::fnJr);
    rom[23] = rType(1, 1, 18, mipsPkg::fnAdd);
    rom[24] = iType(mipsPkg::opLw, 0, 16, 12);
    rom[25] = rType(16, 0, 17, mipsPkg::fnOr);
    // park here
    rom[26] = jType(mipsPkg::opJ, 26);
  endtask

  task automatic preloadMemories();
    mipsPkg::word_t seed;
    seed = 32'h2fa0;
    for (int i = 0; i < MemWords; i++) begin
      seed = xorshift(seed);
      sram[i] <= seed;
      refMem[i] = seed;
    end
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
    refPc = '0;
  endtask

  task automatic expectEqual(input string what, input mipsPkg::word_t got,
                             input mipsPkg::word_t want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // ====================
  // reference model
  // ====================
  task automatic checkCycle();
    mipsPkg::word_t   inst, rsVal, rtVal, imm, addr, pcPlus4, nextPc, wd;
    mipsPkg::regIdx_t wa;
    logic             we, isLoad, isStore;
    inst    = rom[refPc[7:2]];
    rsVal   = refRegs[inst[25:21]];
    rtVal   = refRegs[inst[20:16]];
    imm     = {{16{inst[15]}}, inst[15:0]};
    addr    = rsVal + imm;
    pcPlus4 = refPc + 32'd4;
    nextPc  = pcPlus4;
    wd      = '0;
    wa      = inst[20:16];
    we      = 1'b0;
    isLoad  = 1'b0;
    isStore = 1'b0;
    case (inst[31:26])
      mipsPkg::opR: begin
        wa = inst[15:11];
        we = 1'b1;
        case (inst[5:0])
          mipsPkg::fnAdd: wd = rsVal + rtVal;
          mipsPkg::fnSub: wd = rsVal - rtVal;
          mipsPkg::fnAnd: wd = rsVal & rtVal;
          mipsPkg::fnOr:  wd = rsVal | rtVal;
          mipsPkg::fnSlt: wd = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
          mipsPkg::fnJr: begin
            we     = 1'b0;
            nextPc = rsVal;
          end
          default: we = 1'b0;
        endcase
      end
      mipsPkg::opLw: begin
        isLoad = 1'b1;
        we     = 1'b1;
        wd     = refMem[addr[DataAddrWidth+1:2]];
      end
      mipsPkg::opSw: isStore = 1'b1;
      mipsPkg::opBeq: begin
        if (rsVal == rtVal) begin
          nextPc = pcPlus4 + (imm << 2);
        end
      end
      mipsPkg::opJ: nextPc = {pcPlus4[31:28], inst[25:0], 2'b00};
      mipsPkg::opJal: begin
        nextPc = {pcPlus4[31:28], inst[25:0], 2'b00};
        we     = 1'b1;
        wa     = 5'd31;
        wd     = refPc + 32'd8;
      end
      default: ;
    endcase

    expectEqual("irAddr", irAddr, refPc);
    expectEqual("rfWriteEn", 32'(rfWriteEn), 32'(we));
    if (we) begin
      expectEqual("rfWriteAddr", 32'(rfWriteAddr), 32'(wa));
      expectEqual("rfWriteData", rfWriteData, wd);
    end
    expectEqual("memCen", 32'(memCen), 32'(!(isLoad || isStore)));
    expectEqual("memWen", 32'(memWen), 32'(!isStore));
    if (isLoad || isStore) begin
      expectEqual("memAddr", 32'(memAddr), 32'(addr[DataAddrWidth+1:2]));
    end
    if (isStore) begin
      expectEqual("memWriteData", memWriteData, rtVal);
    end

    // advance to the state after the rising edge
    if (we && (wa != 5'd0)) begin
      refRegs[wa] = wd;
    end
    if (isStore) begin
      refMem[addr[DataAddrWidth+1:2]] = rtVal;
    end
    refPc = nextPc;
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    errors = 0;
    checks = 0;
    rst    = 1'b0;
    loadProgram();
    preloadMemories();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    // sample a quarter period after the falling edge
    for (int n = 0; n < NumCycles; n++) begin
      #(ClkPeriod / 4);
      checkCycle();
      @(negedge clk);
    end
    errors += dut.chk.failures;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("timeout: the run did not finish within %0d ns", WatchdogNs);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- singleCycleMips.f
hdl/mipsPkg.sv
hdl/pcUnit.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/memAccess.sv
hdl/singleCycleMips.sv
tests/singleCycleMips_chk.sv
tests/singleCycleMipsTb.sv

//--- run.sh
#!/bin/sh
# compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing --timescale 1ns/1ps \
  -f singleCycleMips.f --top-module singleCycleMipsTb -o simv

./obj_dir/simv +verilator+error+limit+1000 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
